/* verilog.f */
+incdir+logic
logic/lfb_pkg.sv
logic/lfb_entry_alloc.sv
logic/lfb_data_entry.sv
logic/lfb_line_drain.sv
logic/lfb_data_top.sv
dv/lfb_assertions.sv
dv/lfb_tb.sv

/* dv/lfb_tb.sv */
// testbench for the linefill data buffer
// burst table, LFSR beat data, bus and refill credit models,
// refill monitor with typed compare tasks

`timescale 1ns/10ps

`include "lfb_params.svh"

module lfb_tb;

  import lfb_pkg::*;

  localparam int DLY      = 1;
  localparam int TIMEOUT  = 400;
  localparam int N_ROWS   = 20;
  localparam int HOLD_ROW = 10;
  localparam int FILL_ROW = 12;

  // id, crit, beats, error mask, share per beat, interleave, expect refill
  typedef struct packed {
    bus_id_t    id;
    quarter_t   crit;
    logic [2:0] beats;
    logic [3:0] err_mask;
    logic [3:0] share;
    logic       ilv;
    logic       refill;
  } row_t;

  typedef struct packed {
    line_t   line;
    bus_id_t id;
    logic    share;
  } exp_t;

  row_t rows [N_ROWS] = '{
    '{3'd0, 2'd0, 3'd4, 4'b0000, 4'b1000, 1'b0, 1'b1},
    '{3'd1, 2'd1, 3'd4, 4'b0000, 4'b0111, 1'b0, 1'b1},
    '{3'd2, 2'd2, 3'd4, 4'b0000, 4'b0101, 1'b0, 1'b1},
    '{3'd3, 2'd3, 3'd4, 4'b0000, 4'b1010, 1'b0, 1'b1},
    // read once, then short lines
    '{3'd4, 2'd1, 3'd1, 4'b0000, 4'b0001, 1'b0, 1'b0},
    '{3'd5, 2'd2, 3'd2, 4'b0000, 4'b0000, 1'b0, 1'b0},
    '{3'd6, 2'd3, 3'd3, 4'b0000, 4'b0110, 1'b0, 1'b0},
    // bus error on first, middle and last beat
    '{3'd7, 2'd0, 3'd4, 4'b0001, 4'b0000, 1'b0, 1'b0},
    '{3'd1, 2'd2, 3'd4, 4'b0100, 4'b0000, 1'b0, 1'b0},
    '{3'd2, 2'd3, 3'd4, 4'b1000, 4'b1111, 1'b0, 1'b0},
    // interleaved pair
    '{3'd3, 2'd1, 3'd4, 4'b0000, 4'b1001, 1'b1, 1'b1},
    '{3'd5, 2'd2, 3'd4, 4'b0000, 4'b0110, 1'b0, 1'b1},
    // fill with refill credits withheld
    '{3'd0, 2'd0, 3'd4, 4'b0000, 4'b1100, 1'b0, 1'b1},
    '{3'd1, 2'd1, 3'd4, 4'b0000, 4'b0011, 1'b0, 1'b1},
    '{3'd2, 2'd2, 3'd4, 4'b0000, 4'b1111, 1'b0, 1'b1},
    '{3'd3, 2'd3, 3'd4, 4'b0000, 4'b0000, 1'b0, 1'b1},
    '{3'd4, 2'd0, 3'd4, 4'b0000, 4'b1010, 1'b0, 1'b1},
    '{3'd5, 2'd1, 3'd4, 4'b0000, 4'b0101, 1'b0, 1'b1},
    '{3'd6, 2'd2, 3'd4, 4'b0000, 4'b1001, 1'b0, 1'b1},
    '{3'd7, 2'd3, 3'd4, 4'b0000, 4'b0110, 1'b0, 1'b1}
  };

  logic        lfb_data_entry_clk;
  logic        cpurst_b;
  logic        r_vld;
  logic        r_first;
  bus_id_t     r_id;
  quarter_t    r_crit_idx;
  beat_t       r_data;
  logic        r_last;
  logic        r_err;
  logic        r_share;
  logic        bus_credit_return;
  logic        refill_credit;
  logic        refill_vld;
  bus_id_t     refill_id;
  logic        refill_share;
  line_t       refill_line;

  logic [31:0] lfsr_q;
  exp_t        exp_q [$];
  exp_t        exp_e;
  int          sender_credits;
  int          sent_count;
  int          ret_count;
  int          credit_due;
  logic        hold;
  beat_t       da [4];
  beat_t       db [4];

  lfb_data_top uut (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .r_vld              (r_vld),
    .r_first            (r_first),
    .r_id               (r_id),
    .r_crit_idx         (r_crit_idx),
    .r_data             (r_data),
    .r_last             (r_last),
    .r_err              (r_err),
    .r_share            (r_share),
    .bus_credit_return  (bus_credit_return),
    .refill_credit      (refill_credit),
    .refill_vld         (refill_vld),
    .refill_id          (refill_id),
    .refill_share       (refill_share),
    .refill_line        (refill_line)
  );

  always #50 lfb_data_entry_clk = ~lfb_data_entry_clk;

  //======================================================================
  // reporting and compare tasks
  //======================================================================
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      report_failure("line data compare failed");
    end
  endtask

  task automatic check_id(input string name, input bus_id_t got, input bus_id_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      report_failure("bus id compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      report_failure("flag compare failed");
    end
  endtask

  //======================================================================
  // beat data and burst preparation
  //======================================================================
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_beat(output beat_t b);
    for (int i = 0; i < `LFB_BEAT_W; i++)
    begin
      b[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // beat k lands in quarter (crit + k) mod 4
  task automatic prep_burst(input int r, output beat_t d [4]);
    exp_t e;
    int   q;
    e = '0;
    for (int k = 0; k < rows[r].beats; k++)
    begin
      rand_beat(d[k]);
      q = (rows[r].crit + k) % `LFB_BEATS;
      e.line[q*`LFB_BEAT_W +: `LFB_BEAT_W] = d[k];
    end
    e.id    = rows[r].id;
    e.share = rows[r].share[rows[r].beats-1];
    if (rows[r].refill)
      exp_q.push_back(e);
  endtask

  //======================================================================
  // bus driving and waits
  //======================================================================
  task automatic wait_bus_credit;
    int n;
    n = 0;
    while (sender_credits == 0)
    begin
      r_vld = 1'b0;
      @(posedge lfb_data_entry_clk);
      #DLY;
      n++;
      if (n > TIMEOUT)
        report_failure("timed out waiting for a bus credit");
    end
  endtask

  task automatic drive_beat(input int r, input int k, input beat_t d);
    if (k == 0)
    begin
      wait_bus_credit();
      sender_credits--;
      sent_count++;
    end
    r_vld      = 1'b1;
    r_first    = (k == 0);
    r_id       = rows[r].id;
    r_crit_idx = rows[r].crit;
    r_data     = d;
    r_last     = (k == rows[r].beats - 1);
    r_err      = rows[r].err_mask[k];
    r_share    = rows[r].share[k];
    @(posedge lfb_data_entry_clk);
    #DLY;
  endtask

  task automatic drive_idle;
    r_vld   = 1'b0;
    r_first = 1'b0;
    r_last  = 1'b0;
    r_err   = 1'b0;
  endtask

  // every burst sent has freed its entry and all lines are out
  task automatic wait_drain;
    int n;
    n = 0;
    while (ret_count != sent_count)
    begin
      @(posedge lfb_data_entry_clk);
      #DLY;
      n++;
      if (n > TIMEOUT)
        report_failure("timed out waiting for the buffer to drain");
    end
    check_bit("refill_pending", exp_q.size() != 0, 1'b0);
    check_bit("bus_credits_full", sender_credits == `LFB_ENTRIES, 1'b1);
  endtask

  //======================================================================
  // credit models and refill monitor
  //======================================================================
  always @(posedge lfb_data_entry_clk)
  begin
    #DLY;
    if (credit_due > 0)
    begin
      refill_credit = 1'b1;
      credit_due--;
    end
    else
      refill_credit = 1'b0;
  end

  always @(negedge lfb_data_entry_clk)
  begin
    if (cpurst_b && refill_vld)
    begin
      if (exp_q.size() == 0)
        report_failure("refill_vld high while no line was expected");
      else
      begin
        exp_e = exp_q.pop_front();
        check_id("refill_id", refill_id, exp_e.id);
        check_bit("refill_share", refill_share, exp_e.share);
        check_line("refill_line", refill_line, exp_e.line);
        // the refilled entry frees its bus credit in the same cycle
        check_bit("bus_credit_return", bus_credit_return, 1'b1);
        // consumer takes the line and grants a new credit
        if (!hold)
          credit_due++;
      end
    end
    if (cpurst_b && bus_credit_return)
    begin
      ret_count++;
      sender_credits++;
      if (ret_count > sent_count)
        report_failure("bus credit returned with no burst outstanding");
    end
  end

  //======================================================================
  // main sequence
  //======================================================================
  initial
  begin
    lfb_data_entry_clk = 1'b0;
    cpurst_b           = 1'b0;
    r_vld              = 1'b0;
    r_first            = 1'b0;
    r_id               = '0;
    r_crit_idx         = '0;
    r_data             = '0;
    r_last             = 1'b0;
    r_err              = 1'b0;
    r_share            = 1'b0;
    refill_credit      = 1'b0;
    lfsr_q             = 32'h7a7c;
    sender_credits     = `LFB_ENTRIES;
    sent_count         = 0;
    ret_count          = 0;
    credit_due         = 0;
    hold               = 1'b0;

    repeat (16) @(posedge lfb_data_entry_clk);
    #DLY;
    cpurst_b = 1'b1;
    @(posedge lfb_data_entry_clk);
    #DLY;

    // single bursts and the interleaved pair drained one by one
    for (int r = 0; r < FILL_ROW; r++)
    begin
      // refills from here on keep their credits
      if (r == HOLD_ROW)
        hold = 1'b1;
      if (rows[r].ilv)
      begin
        prep_burst(r, da);
        prep_burst(r + 1, db);
        for (int k = 0; k < `LFB_BEATS; k++)
        begin
          if (k < rows[r].beats)
            drive_beat(r, k, da[k]);
          if (k < rows[r+1].beats)
            drive_beat(r + 1, k, db[k]);
        end
        r++;
      end
      else
      begin
        prep_burst(r, da);
        for (int k = 0; k < rows[r].beats; k++)
          drive_beat(r, k, da[k]);
      end
      drive_idle();
      wait_drain();
    end

    // eight lines fill the buffer with no refill credits left
    for (int r = FILL_ROW; r < N_ROWS; r++)
    begin
      prep_burst(r, da);
      for (int k = 0; k < rows[r].beats; k++)
        drive_beat(r, k, da[k]);
    end
    drive_idle();
    repeat (10) @(posedge lfb_data_entry_clk);
    #DLY;
    check_bit("bus_stall", sender_credits == 0, 1'b1);
    check_bit("lines_held", exp_q.size() == `LFB_ENTRIES, 1'b1);

    // released lines leave in allocation order
    hold       = 1'b0;
    credit_due = credit_due + `LFB_REFILL_CREDITS;
    wait_drain();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* dv/lfb_assertions.sv */
// protocol checks for the linefill data buffer
// first beat needs a free entry, one-hot pop, refill only under credit

`timescale 1ns/10ps

module lfb_assertions (
  input logic                  lfb_data_entry_clk,
  input logic                  cpurst_b,
  input logic                  r_vld,
  input logic                  r_first,
  input lfb_pkg::entry_vec_t   entry_vld,
  input lfb_pkg::entry_vec_t   entry_pop,
  input logic                  refill_vld,
  input lfb_pkg::credit_cnt_t  credit_cnt
);

  // sender must hold a credit, so some entry is free
  a_first_has_entry : assert property (@(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    (r_vld && r_first) |-> !(&entry_vld))
    else $error("first beat arrived while every entry was valid");

  a_pop_onehot : assert property (@(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    $onehot0(entry_pop))
    else $error("more than one entry popped in a cycle");

  // credit was spent on the edge that raised refill_vld
  a_refill_credit : assert property (@(posedge lfb_data_entry_clk) disable iff (!cpurst_b)
    refill_vld |-> ($past(credit_cnt) != '0))
    else $error("refill issued without a refill credit");

endmodule

bind lfb_data_top lfb_assertions u_assert (
  .lfb_data_entry_clk (lfb_data_entry_clk),
  .cpurst_b           (cpurst_b),
  .r_vld              (r_vld),
  .r_first            (r_first),
  .entry_vld          (entry_vld),
  .entry_pop          (entry_pop),
  .refill_vld         (refill_vld),
  .credit_cnt         (u_drain.credit_cnt)
);

/* logic/lfb_data_top.sv */
// top level of the linefill data buffer
// allocator, generate loop of data entries, line drain

`timescale 1ns/10ps

`include "lfb_params.svh"

module lfb_data_top (
  input  logic              lfb_data_entry_clk,
  input  logic              cpurst_b,
  input  logic              r_vld,
  input  logic              r_first,
  input  lfb_pkg::bus_id_t  r_id,
  input  lfb_pkg::quarter_t r_crit_idx,
  input  lfb_pkg::beat_t    r_data,
  input  logic              r_last,
  input  logic              r_err,
  input  logic              r_share,
  output logic              bus_credit_return,
  input  logic              refill_credit,
  output logic              refill_vld,
  output lfb_pkg::bus_id_t  refill_id,
  output logic              refill_share,
  output lfb_pkg::line_t    refill_line
);

  import lfb_pkg::*;

  entry_vec_t entry_create;
  entry_vec_t entry_vld;
  entry_vec_t entry_done;
  entry_vec_t entry_discard;
  entry_vec_t entry_share;
  entry_vec_t entry_pop;
  bus_id_t    entry_id [`LFB_ENTRIES];
  line_t      entry_line [`LFB_ENTRIES];
  logic       pop_any;

  lfb_entry_alloc u_alloc (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .r_vld              (r_vld),
    .r_first            (r_first),
    .entry_vld          (entry_vld),
    .pop_any            (pop_any),
    .entry_create       (entry_create),
    .bus_credit_return  (bus_credit_return)
  );

  for (genvar g = 0; g < `LFB_ENTRIES; g++)
  begin : g_entry
    lfb_data_entry u_entry (
      .lfb_data_entry_clk (lfb_data_entry_clk),
      .cpurst_b           (cpurst_b),
      .create             (entry_create[g]),
      .pop                (entry_pop[g]),
      .r_vld              (r_vld),
      .r_id               (r_id),
      .r_crit_idx         (r_crit_idx),
      .r_data             (r_data),
      .r_last             (r_last),
      .r_err              (r_err),
      .r_share            (r_share),
      .entry_vld          (entry_vld[g]),
      .entry_done         (entry_done[g]),
      .entry_discard      (entry_discard[g]),
      .entry_id           (entry_id[g]),
      .entry_share        (entry_share[g]),
      .entry_line         (entry_line[g])
    );
  end

  lfb_line_drain u_drain (
    .lfb_data_entry_clk (lfb_data_entry_clk),
    .cpurst_b           (cpurst_b),
    .entry_done         (entry_done),
    .entry_discard      (entry_discard),
    .entry_id           (entry_id),
    .entry_share        (entry_share),
    .entry_line         (entry_line),
    .refill_credit      (refill_credit),
    .entry_pop          (entry_pop),
    .pop_any            (pop_any),
    .refill_vld         (refill_vld),
    .refill_id          (refill_id),
    .refill_share       (refill_share),
    .refill_line        (refill_line)
  );

endmodule

/* logic/lfb_line_drain.sv */
// line drain of the linefill data buffer
// lowest-entry select over discards and credited done lines,
// one-hot pop, refill credit counter, registered refill outputs

`timescale 1ns/10ps

`include "lfb_params.svh"

module lfb_line_drain (
  input  logic                lfb_data_entry_clk,
  input  logic                cpurst_b,
  input  lfb_pkg::entry_vec_t entry_done,
  input  lfb_pkg::entry_vec_t entry_discard,
  input  lfb_pkg::bus_id_t    entry_id [`LFB_ENTRIES],
  input  lfb_pkg::entry_vec_t entry_share,
  input  lfb_pkg::line_t      entry_line [`LFB_ENTRIES],
  input  logic                refill_credit,
  output lfb_pkg::entry_vec_t entry_pop,
  output logic                pop_any,
  output logic                refill_vld,
  output lfb_pkg::bus_id_t    refill_id,
  output logic                refill_share,
  output lfb_pkg::line_t      refill_line
);

  import lfb_pkg::*;

  credit_cnt_t credit_cnt;
  logic        have_credit;
  entry_vec_t  cand;
  entry_idx_t  sel_idx;
  logic        sel_found;
  logic        pop_refill;

  //======================================================================
  // select
  //======================================================================
  assign have_credit = (credit_cnt != '0);
  // discards drain without a credit
  assign cand = entry_discard | (entry_done & {`LFB_ENTRIES{have_credit}});

  always_comb
  begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = `LFB_ENTRIES-1; i >= 0; i--)
    begin
      if (cand[i])
      begin
        sel_found = 1'b1;
        sel_idx   = entry_idx_t'(i);
      end
    end
  end

  assign entry_pop  = sel_found ? (entry_vec_t'(1) << sel_idx) : '0;
  assign pop_any    = sel_found;
  assign pop_refill = |(entry_pop & entry_done);

  //======================================================================
  // refill credits
  //======================================================================
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      credit_cnt <= credit_cnt_t'(`LFB_REFILL_CREDITS);
    else if (refill_credit && !pop_refill)
      credit_cnt <= credit_cnt + 1'b1;
    else if (!refill_credit && pop_refill)
      credit_cnt <= credit_cnt - 1'b1;
  end

  //======================================================================
  // refill outputs
  //======================================================================
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      refill_vld <= 1'b0;
    else
      refill_vld <= pop_refill;
  end

  always_ff @(posedge lfb_data_entry_clk)
  begin
    if (pop_refill)
    begin
      refill_id    <= entry_id[sel_idx];
      refill_share <= entry_share[sel_idx];
      refill_line  <= entry_line[sel_idx];
    end
  end

endmodule

/* logic/lfb_data_entry.sv */
// one linefill data entry
// beat capture by bus id with critical-word-first placement,
// beat count, last flag, sticky error, share flag,
// done or discard decision for the drain

`timescale 1ns/10ps

`include "lfb_params.svh"

module lfb_data_entry (
  input  logic              lfb_data_entry_clk,
  input  logic              cpurst_b,
  input  logic              create,
  input  logic              pop,
  input  logic              r_vld,
  input  lfb_pkg::bus_id_t  r_id,
  input  lfb_pkg::quarter_t r_crit_idx,
  input  lfb_pkg::beat_t    r_data,
  input  logic              r_last,
  input  logic              r_err,
  input  logic              r_share,
  output logic              entry_vld,
  output logic              entry_done,
  output logic              entry_discard,
  output lfb_pkg::bus_id_t  entry_id,
  output logic              entry_share,
  output lfb_pkg::line_t    entry_line
);

  import lfb_pkg::*;

  logic         vld_q;
  logic         last_q;
  logic         err_q;
  logic         share_q;
  quarter_t     cnt_q;
  quarter_ptr_t ptr_q;
  bus_id_t      id_q;
  line_t        line_q;

  logic         id_hit;
  logic         take_beat;
  logic         full_line;
  quarter_ptr_t crit_ptr;
  quarter_ptr_t wr_ptr;

  //======================================================================
  // beat match and placement
  //======================================================================
  // later beats of the same burst, never a new first beat
  assign id_hit    = vld_q && !last_q && r_vld && (id_q == r_id);
  assign take_beat = create || id_hit;

  assign crit_ptr = quarter_ptr_t'(1) << r_crit_idx;
  assign wr_ptr   = create ? crit_ptr : (id_hit ? ptr_q : '0);

  //======================================================================
  // control state
  //======================================================================
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld_q <= 1'b0;
    else if (pop)
      vld_q <= 1'b0;
    else if (create)
      vld_q <= 1'b1;
  end

  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cnt_q   <= '0;
      last_q  <= 1'b0;
      err_q   <= 1'b0;
      share_q <= 1'b0;
      ptr_q   <= quarter_ptr_t'(1);
    end
    else if (create)
    begin
      cnt_q   <= '0;
      last_q  <= r_last;
      err_q   <= r_err;
      share_q <= r_share;
      // next beat goes one quarter above the critical one
      ptr_q   <= {crit_ptr[`LFB_BEATS-2:0], crit_ptr[`LFB_BEATS-1]};
    end
    else if (id_hit)
    begin
      cnt_q   <= cnt_q + 1'b1;
      last_q  <= r_last;
      err_q   <= err_q || r_err;
      share_q <= r_share;
      ptr_q   <= {ptr_q[`LFB_BEATS-2:0], ptr_q[`LFB_BEATS-1]};
    end
  end

  //======================================================================
  // payload
  //======================================================================
  always_ff @(posedge lfb_data_entry_clk)
  begin
    if (create)
      id_q <= r_id;
  end

  always_ff @(posedge lfb_data_entry_clk)
  begin
    if (take_beat)
    begin
      for (int q = 0; q < `LFB_BEATS; q++)
      begin
        if (wr_ptr[q])
          line_q[q*`LFB_BEAT_W +: `LFB_BEAT_W] <= r_data;
      end
    end
  end

  //======================================================================
  // done or discard
  //======================================================================
  // cnt counts beats minus one, so a whole line ends at LFB_BEATS-1
  assign full_line = (cnt_q == quarter_t'(`LFB_BEATS-1)) && !err_q;

  assign entry_vld     = vld_q;
  assign entry_done    = vld_q && last_q && full_line;
  // read once, short line or bus error
  assign entry_discard = vld_q && last_q && !full_line;
  assign entry_id      = id_q;
  assign entry_share   = share_q;
  assign entry_line    = line_q;

endmodule

/* logic/lfb_entry_alloc.sv */
// entry allocator of the linefill data buffer
// one-hot create for the lowest free entry on a first beat
// registered bus credit return, one pulse per freed entry

`timescale 1ns/10ps

`include "lfb_params.svh"

module lfb_entry_alloc (
  input  logic               lfb_data_entry_clk,
  input  logic               cpurst_b,
  input  logic               r_vld,
  input  logic               r_first,
  input  lfb_pkg::entry_vec_t entry_vld,
  input  logic               pop_any,
  output lfb_pkg::entry_vec_t entry_create,
  output logic               bus_credit_return
);

  import lfb_pkg::*;

  entry_vec_t free_vec;
  entry_vec_t lowest_free;
  logic       first_beat;

  //======================================================================
  // create select
  //======================================================================
  assign free_vec   = ~entry_vld;
  assign first_beat = r_vld && r_first;

  // lowest set bit of the free vector
  always_comb
  begin
    lowest_free = '0;
    for (int i = `LFB_ENTRIES-1; i >= 0; i--)
    begin
      if (free_vec[i])
      begin
        lowest_free    = '0;
        lowest_free[i] = 1'b1;
      end
    end
  end

  // the sender holds a credit per free entry, so a first beat
  // always finds a free slot here
  assign entry_create = first_beat ? lowest_free : '0;

  //======================================================================
  // bus credit return
  //======================================================================
  // one cycle after the pop, aligned with refill_vld
  always_ff @(posedge lfb_data_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bus_credit_return <= 1'b0;
    else
      bus_credit_return <= pop_any;
  end

endmodule

/* logic/lfb_pkg.sv */
// shared types of the linefill data buffer
// beat, line, bus id, quarter index and pointer,
// entry vector and index, refill credit count

`include "lfb_params.svh"

package lfb_pkg;

  //====================================================================
  // bus side
  //====================================================================
  typedef logic [`LFB_BEAT_W-1:0]              beat_t;
  typedef logic [`LFB_ID_W-1:0]                bus_id_t;

  //====================================================================
  // line geometry
  //====================================================================
  typedef logic [`LFB_BEAT_W*`LFB_BEATS-1:0]   line_t;
  // quarter index, critical word position
  typedef logic [$clog2(`LFB_BEATS)-1:0]       quarter_t;
  // one-hot write pointer over the quarters
  typedef logic [`LFB_BEATS-1:0]               quarter_ptr_t;

  //====================================================================
  // entry bookkeeping
  //====================================================================
  typedef logic [`LFB_ENTRIES-1:0]             entry_vec_t;
  typedef logic [$clog2(`LFB_ENTRIES)-1:0]     entry_idx_t;
  // wide enough for the reset credit count
  typedef logic [$clog2(`LFB_REFILL_CREDITS+1)-1:0] credit_cnt_t;

endpackage

/* logic/lfb_params.svh */
// linefill buffer sizing macros
// entry count, beat and line geometry, bus id width, refill credits

`ifndef LFB_PARAMS_SVH
`define LFB_PARAMS_SVH

// number of data entries
`define LFB_ENTRIES 8

// bus read beat width in bits
`define LFB_BEAT_W 128

// beats per cache line
`define LFB_BEATS 4

// bus transaction id width
`define LFB_ID_W 3

// refill credits held by the drain out of reset
`define LFB_REFILL_CREDITS 2

`endif
